// ==== hw/isa_pkg.sv ====
package isa_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int shamt_w     = $clog2(xlen);
    localparam int div_steps   = 32;
    localparam int div_cnt_w   = $clog2(div_steps);
    localparam int link_offset = 4;

    // Top bits select the class: 0x ALU, 10 multiply, 11 divide.
    typedef enum logic [4:0] {
        op_add   = 5'b00000,
        op_sub   = 5'b00001,
        op_slt   = 5'b00010,
        op_sltu  = 5'b00011,
        op_eq    = 5'b00100,
        op_and   = 5'b00101,
        op_or    = 5'b00110,
        op_xor   = 5'b00111,
        op_nor   = 5'b01000,
        op_sll   = 5'b01001,
        op_srl   = 5'b01010,
        op_sra   = 5'b01011,
        op_mul   = 5'b10000,
        op_mulh  = 5'b10001,
        op_mulhu = 5'b10010,
        op_div   = 5'b11000,
        op_mod   = 5'b11001,
        op_divu  = 5'b11010,
        op_modu  = 5'b11011
    } opcode_t;

    function automatic logic is_alu_op(opcode_t op);
        return op[4] == 1'b0;
    endfunction

    function automatic logic is_mul_op(opcode_t op);
        return op[4:3] == 2'b10;
    endfunction

    function automatic logic is_div_op(opcode_t op);
        return op[4:3] == 2'b11;
    endfunction

endpackage

// ==== hw/ex_pkg.sv ====
package ex_pkg;

    typedef struct packed {
        isa_pkg::opcode_t                  opcode;
        logic [isa_pkg::xlen-1:0]          pc;
        logic [isa_pkg::xlen-1:0]          src1;
        logic [isa_pkg::xlen-1:0]          src2;
        logic [isa_pkg::reg_addr_w-1:0]    dest;
        logic                              is_branch;
        logic                              branch_condition;
        logic [isa_pkg::xlen-1:0]          branch_target;
        logic                              is_jirl;
        logic                              pred_taken;
        logic [isa_pkg::xlen-1:0]          pred_target;
    } ex_req_t;

    typedef struct packed {
        logic [isa_pkg::xlen-1:0]          pc;
        logic [isa_pkg::xlen-1:0]          result;
        logic [isa_pkg::reg_addr_w-1:0]    dest;
        logic                              branch_taken;
        logic [isa_pkg::xlen-1:0]          branch_target;
        logic                              branch_mistaken;
    } ex_resp_t;

    // Source of the written-back result.
    typedef enum logic [2:0] {
        sel_alu,
        sel_mul_lo,
        sel_mul_hi,
        sel_quot,
        sel_rem,
        sel_link
    } result_sel_t;

    typedef enum logic [1:0] {
        st_idle,
        st_mul,
        st_div,
        st_done
    } ex_state_t;

endpackage

// ==== hw/div_counter.sv ====
module div_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic enable,
    output logic last
);

    logic [isa_pkg::div_cnt_w-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= isa_pkg::div_cnt_w'(isa_pkg::div_steps - 1);
        end else if (enable && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Count reaches zero on the final step.
    assign last = enable && count == '0;

    a_clear_enable_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear && enable));

endmodule

// ==== hw/alu.sv ====
module alu (
    input  isa_pkg::opcode_t          op,
    input  logic [isa_pkg::xlen-1:0]  src1,
    input  logic [isa_pkg::xlen-1:0]  src2,
    output logic [isa_pkg::xlen-1:0]  result
);

    logic [isa_pkg::shamt_w-1:0] shamt;

    assign shamt = src2[isa_pkg::shamt_w-1:0];

    always_comb begin
        case (op)
            isa_pkg::op_add:  result = src1 + src2;
            isa_pkg::op_sub:  result = src1 - src2;
            isa_pkg::op_slt: begin
                result = {{(isa_pkg::xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            isa_pkg::op_sltu: begin
                result = {{(isa_pkg::xlen-1){1'b0}}, src1 < src2};
            end
            isa_pkg::op_eq: begin
                result = {{(isa_pkg::xlen-1){1'b0}}, src1 == src2};
            end
            isa_pkg::op_and:  result = src1 & src2;
            isa_pkg::op_or:   result = src1 | src2;
            isa_pkg::op_xor:  result = src1 ^ src2;
            isa_pkg::op_nor:  result = ~(src1 | src2);
            isa_pkg::op_sll:  result = src1 << shamt;
            isa_pkg::op_srl:  result = src1 >> shamt;
            isa_pkg::op_sra:  result = $signed(src1) >>> shamt;
            default:          result = '0;
        endcase
    end

endmodule

// ==== hw/muldiv_unit.sv ====
module muldiv_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  isa_pkg::opcode_t          op,
    input  logic [isa_pkg::xlen-1:0]  src1,
    input  logic [isa_pkg::xlen-1:0]  src2,
    input  logic                      mul_en,
    input  logic                      div_start,
    input  logic                      div_step,
    output logic [isa_pkg::xlen-1:0]  mul_lo,
    output logic [isa_pkg::xlen-1:0]  mul_hi,
    output logic [isa_pkg::xlen-1:0]  quotient,
    output logic [isa_pkg::xlen-1:0]  remainder
);

    logic                             mul_sign_ex;
    logic [isa_pkg::xlen:0]           mul_a;
    logic [isa_pkg::xlen:0]           mul_b;
    logic signed [2*isa_pkg::xlen+1:0] product;

    logic                             div_signed;
    logic [isa_pkg::xlen-1:0]         dividend_mag;
    logic [isa_pkg::xlen-1:0]         divisor_mag;
    logic [isa_pkg::xlen-1:0]         quo;
    logic [isa_pkg::xlen-1:0]         rem;
    logic [isa_pkg::xlen-1:0]         dvsr;
    logic                             quot_neg;
    logic                             rem_neg;
    logic [isa_pkg::xlen:0]           shifted;
    logic [isa_pkg::xlen:0]           trial;
    logic                             fits;

    // Only mulh treats its operands as signed.
    assign mul_sign_ex = op == isa_pkg::op_mulh;
    assign mul_a = {mul_sign_ex && src1[isa_pkg::xlen-1], src1};
    assign mul_b = {mul_sign_ex && src2[isa_pkg::xlen-1], src2};

    always_ff @(posedge clk) begin
        if (mul_en) begin
            product <= $signed(mul_a) * $signed(mul_b);
        end
    end

    assign mul_lo = product[isa_pkg::xlen-1:0];
    assign mul_hi = product[2*isa_pkg::xlen-1:isa_pkg::xlen];

    assign div_signed   = op == isa_pkg::op_div || op == isa_pkg::op_mod;
    assign dividend_mag = (div_signed && src1[isa_pkg::xlen-1]) ? -src1 : src1;
    assign divisor_mag  = (div_signed && src2[isa_pkg::xlen-1]) ? -src2 : src2;

    // One restoring step: shift in the next dividend bit and try to subtract.
    assign shifted = {rem, quo[isa_pkg::xlen-1]};
    assign trial   = shifted - {1'b0, dvsr};
    assign fits    = shifted >= {1'b0, dvsr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quot_neg <= 1'b0;
            rem_neg  <= 1'b0;
        end else if (div_start) begin
            quot_neg <= div_signed && (src1[isa_pkg::xlen-1] ^ src2[isa_pkg::xlen-1]);
            rem_neg  <= div_signed && src1[isa_pkg::xlen-1];
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem  <= '0;
            quo  <= dividend_mag;
            dvsr <= divisor_mag;
        end else if (div_step) begin
            rem <= fits ? trial[isa_pkg::xlen-1:0] : shifted[isa_pkg::xlen-1:0];
            quo <= {quo[isa_pkg::xlen-2:0], fits};
        end
    end

    assign quotient  = quot_neg ? -quo : quo;
    assign remainder = rem_neg ? -rem : rem;

endmodule

// ==== hw/branch_unit.sv ====
module branch_unit (
    input  ex_pkg::ex_req_t           req,
    input  logic [isa_pkg::xlen-1:0]  alu_result,
    output logic                      branch_taken,
    output logic [isa_pkg::xlen-1:0]  branch_target,
    output logic                      branch_mistaken,
    output logic [isa_pkg::xlen-1:0]  link_addr
);

    logic direction_wrong;
    logic target_wrong;

    // Conditional branches compare the ALU flag with the wanted condition.
    assign branch_taken = req.is_branch
                       && (req.is_jirl || req.branch_condition == alu_result[0]);

    // A jirl target is the register sum computed by the ALU.
    assign branch_target = req.is_jirl ? alu_result : req.branch_target;

    assign direction_wrong = branch_taken != req.pred_taken;
    assign target_wrong    = branch_taken && branch_target != req.pred_target;
    assign branch_mistaken = direction_wrong || target_wrong;

    assign link_addr = req.pc + isa_pkg::xlen'(isa_pkg::link_offset);

endmodule

// ==== hw/ex_ctrl.sv ====
module ex_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 in_valid,
    input  ex_pkg::ex_req_t      in_req,
    input  logic                 allowout,
    input  logic                 div_last,
    output logic                 stall,
    output logic                 out_valid,
    output ex_pkg::ex_req_t      held_req,
    output ex_pkg::result_sel_t  result_sel,
    output logic                 mul_en,
    output logic                 div_start,
    output logic                 div_step,
    output logic                 count_clear,
    output logic                 count_en
);

    ex_pkg::ex_state_t    state;
    ex_pkg::ex_state_t    state_entry;
    ex_pkg::result_sel_t  sel_entry;
    logic                 held_valid;
    logic                 div_busy;
    logic                 accept;
    logic                 leave;

    assign out_valid = held_valid && state == ex_pkg::st_done;
    assign stall     = held_valid && !(out_valid && allowout);
    assign accept    = in_valid && !stall;
    assign leave     = out_valid && allowout;

    assign mul_en      = state == ex_pkg::st_mul;
    // First cycle in st_div loads the divider, the rest are steps.
    assign div_start   = state == ex_pkg::st_div && !div_busy;
    assign div_step    = div_busy;
    assign count_clear = div_start;
    assign count_en    = div_busy;

    // Class decode of the incoming instruction.
    always_comb begin
        if (isa_pkg::is_mul_op(in_req.opcode)) begin
            state_entry = ex_pkg::st_mul;
        end else if (isa_pkg::is_div_op(in_req.opcode)) begin
            state_entry = ex_pkg::st_div;
        end else begin
            state_entry = ex_pkg::st_done;
        end

        if (in_req.is_jirl) begin
            sel_entry = ex_pkg::sel_link;
        end else if (isa_pkg::is_alu_op(in_req.opcode)) begin
            sel_entry = ex_pkg::sel_alu;
        end else begin
            case (in_req.opcode)
                isa_pkg::op_mul:                   sel_entry = ex_pkg::sel_mul_lo;
                isa_pkg::op_mulh, isa_pkg::op_mulhu: sel_entry = ex_pkg::sel_mul_hi;
                isa_pkg::op_div, isa_pkg::op_divu: sel_entry = ex_pkg::sel_quot;
                default:                           sel_entry = ex_pkg::sel_rem;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            state      <= ex_pkg::st_idle;
            div_busy   <= 1'b0;
        end else if (flush) begin
            held_valid <= 1'b0;
            state      <= ex_pkg::st_idle;
            div_busy   <= 1'b0;
        end else begin
            div_busy <= state == ex_pkg::st_div && !div_last;
            if (accept) begin
                held_valid <= 1'b1;
                state      <= state_entry;
            end else if (leave) begin
                held_valid <= 1'b0;
                state      <= ex_pkg::st_idle;
            end else if (state == ex_pkg::st_mul) begin
                state <= ex_pkg::st_done;
            end else if (state == ex_pkg::st_div && div_last) begin
                state <= ex_pkg::st_done;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_req   <= in_req;
            result_sel <= sel_entry;
        end
    end

    // A held instruction is never left in idle, and an empty stage never sits in a busy state.
    a_valid_matches_state: assert property (@(posedge clk) disable iff (!rst_n)
        held_valid == (state != ex_pkg::st_idle));

    a_step_only_in_div: assert property (@(posedge clk) disable iff (!rst_n)
        div_step |-> state == ex_pkg::st_div);

endmodule

// ==== hw/ex_stage.sv ====
module ex_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              in_valid,
    input  ex_pkg::ex_req_t   in_req,
    output logic              stall,
    input  logic              allowout,
    output logic              out_valid,
    output ex_pkg::ex_resp_t  out_resp
);

    ex_pkg::ex_req_t           held_req;
    ex_pkg::result_sel_t       result_sel;
    logic                      mul_en;
    logic                      div_start;
    logic                      div_step;
    logic                      count_clear;
    logic                      count_en;
    logic                      div_last;
    logic [isa_pkg::xlen-1:0]  alu_result;
    logic [isa_pkg::xlen-1:0]  mul_lo;
    logic [isa_pkg::xlen-1:0]  mul_hi;
    logic [isa_pkg::xlen-1:0]  quotient;
    logic [isa_pkg::xlen-1:0]  remainder;
    logic [isa_pkg::xlen-1:0]  link_addr;
    logic                      branch_taken;
    logic [isa_pkg::xlen-1:0]  branch_target;
    logic                      branch_mistaken;
    logic [isa_pkg::xlen-1:0]  result;

    ex_ctrl ex_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .allowout    (allowout),
        .div_last    (div_last),
        .stall       (stall),
        .out_valid   (out_valid),
        .held_req    (held_req),
        .result_sel  (result_sel),
        .mul_en      (mul_en),
        .div_start   (div_start),
        .div_step    (div_step),
        .count_clear (count_clear),
        .count_en    (count_en)
    );

    div_counter div_counter_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (count_clear),
        .enable (count_en),
        .last   (div_last)
    );

    alu alu_inst (
        .op     (held_req.opcode),
        .src1   (held_req.src1),
        .src2   (held_req.src2),
        .result (alu_result)
    );

    muldiv_unit muldiv_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (held_req.opcode),
        .src1      (held_req.src1),
        .src2      (held_req.src2),
        .mul_en    (mul_en),
        .div_start (div_start),
        .div_step  (div_step),
        .mul_lo    (mul_lo),
        .mul_hi    (mul_hi),
        .quotient  (quotient),
        .remainder (remainder)
    );

    branch_unit branch_unit_inst (
        .req             (held_req),
        .alu_result      (alu_result),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .branch_mistaken (branch_mistaken),
        .link_addr       (link_addr)
    );

    always_comb begin
        case (result_sel)
            ex_pkg::sel_mul_lo: result = mul_lo;
            ex_pkg::sel_mul_hi: result = mul_hi;
            ex_pkg::sel_quot:   result = quotient;
            ex_pkg::sel_rem:    result = remainder;
            ex_pkg::sel_link:   result = link_addr;
            default:            result = alu_result;
        endcase
    end

    always_comb begin
        out_resp.pc              = held_req.pc;
        out_resp.result          = result;
        out_resp.dest            = held_req.dest;
        out_resp.branch_taken    = branch_taken;
        out_resp.branch_target   = branch_target;
        out_resp.branch_mistaken = branch_mistaken;
    end

endmodule

// ==== bench/ex_stage_tb.sv ====
module ex_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              in_valid;
    logic              stall;
    logic              allowout;
    logic              out_valid;
    ex_pkg::ex_req_t   in_req;
    ex_pkg::ex_resp_t  out_resp;
    logic [31:0]       rng_state;

    ex_stage ex_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .stall     (stall),
        .allowout  (allowout),
        .out_valid (out_valid),
        .out_resp  (out_resp)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic ex_pkg::ex_req_t make_req(isa_pkg::opcode_t op, logic [31:0] a,
                                                 logic [31:0] b);
        ex_pkg::ex_req_t req;
        req        = '0;
        req.opcode = op;
        req.pc     = next_random() & 32'hffff_fffc;
        req.dest   = isa_pkg::reg_addr_w'(next_random());
        req.src1   = a;
        req.src2   = b;
        return req;
    endfunction

    // Expected values follow the opcode definitions directly.
    function automatic logic [31:0] alu_model(isa_pkg::opcode_t op, logic [31:0] a,
                                              logic [31:0] b);
        case (op)
            isa_pkg::op_add:  return a + b;
            isa_pkg::op_sub:  return a - b;
            isa_pkg::op_slt:  return {31'b0, $signed(a) < $signed(b)};
            isa_pkg::op_sltu: return {31'b0, a < b};
            isa_pkg::op_eq:   return {31'b0, a == b};
            isa_pkg::op_and:  return a & b;
            isa_pkg::op_or:   return a | b;
            isa_pkg::op_xor:  return a ^ b;
            isa_pkg::op_nor:  return ~(a | b);
            isa_pkg::op_sll:  return a << b[4:0];
            isa_pkg::op_srl:  return a >> b[4:0];
            default:          return $signed(a) >>> b[4:0];
        endcase
    endfunction

    function automatic logic [31:0] muldiv_model(isa_pkg::opcode_t op, logic [31:0] a,
                                                 logic [31:0] b);
        logic [63:0] full;
        full = {32'b0, a} * {32'b0, b};
        case (op)
            isa_pkg::op_mul:   return full[31:0];
            isa_pkg::op_mulhu: return full[63:32];
            isa_pkg::op_mulh: begin
                full = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                return full[63:32];
            end
            isa_pkg::op_div:   return $signed(a) / $signed(b);
            isa_pkg::op_mod:   return $signed(a) % $signed(b);
            isa_pkg::op_divu:  return a / b;
            default:           return a % b;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the accepting edge.
    task automatic issue(input ex_pkg::ex_req_t req);
        int cycles;
        cycles   = 0;
        in_valid = 1'b1;
        in_req   = req;
        while (stall) begin
            if (cycles >= 100) begin
                abort_run("Timeout: the stage kept stall high and never took the request.");
            end
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_result(input int limit);
        int cycles;
        cycles = 0;
        while (!out_valid) begin
            check_eq("stall", stall, 1'b1);
            if (cycles >= limit) begin
                abort_run("Timeout: out_valid did not rise for a multi-cycle operation.");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_resp(input ex_pkg::ex_req_t req, input logic [31:0] exp);
        check_eq("out_resp.result", out_resp.result, exp);
        check_eq("out_resp.dest", out_resp.dest, req.dest);
        check_eq("out_resp.pc", out_resp.pc, req.pc);
    endtask

    task automatic test_reset();
        check_eq("out_valid", out_valid, 1'b0);
        check_eq("stall", stall, 1'b0);
    endtask

    task automatic test_alu();
        ex_pkg::ex_req_t req;
        isa_pkg::opcode_t op;
        for (int i = 0; i < 12; i++) begin
            op = isa_pkg::opcode_t'(i);
            for (int n = 0; n < 4; n++) begin
                req = make_req(op, next_random(), next_random());
                // Equal operands so op_eq also sees a true case.
                if (n == 0) begin
                    req.src2 = req.src1;
                end
                issue(req);
                check_eq("out_valid", out_valid, 1'b1);
                check_resp(req, alu_model(op, req.src1, req.src2));
            end
        end
    endtask

    task automatic test_muldiv();
        ex_pkg::ex_req_t req;
        isa_pkg::opcode_t ops [$];
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        ops = '{isa_pkg::op_mul, isa_pkg::op_mulh, isa_pkg::op_mulhu, isa_pkg::op_div,
                isa_pkg::op_mod, isa_pkg::op_divu, isa_pkg::op_modu};
        foreach (ops[k]) begin
            for (int s = 0; s < 4; s++) begin
                mag_a = next_random() >> 1;
                mag_b = next_random() >> (1 + next_random() % 20);
                if (mag_b == 32'd0) begin
                    mag_b = 32'd3;
                end
                req = make_req(ops[k], s[0] ? -mag_a : mag_a, s[1] ? -mag_b : mag_b);
                issue(req);
                wait_result(isa_pkg::is_mul_op(ops[k]) ? 4 : 40);
                check_resp(req, muldiv_model(ops[k], req.src1, req.src2));
            end
        end
    endtask

    task automatic test_branches();
        ex_pkg::ex_req_t req;
        logic taken;
        for (int i = 0; i < 16; i++) begin
            req = make_req(isa_pkg::op_eq, next_random(), 32'd0);
            req.src2             = i[1] ? req.src1 : req.src1 ^ (next_random() | 32'd1);
            req.is_branch        = 1'b1;
            req.branch_condition = i[0];
            req.branch_target    = next_random() & 32'hffff_fffc;
            req.pred_taken       = i[2];
            req.pred_target      = i[3] ? req.branch_target : req.branch_target ^ 32'h100;
            taken = i[0] == i[1];
            issue(req);
            check_eq("out_valid", out_valid, 1'b1);
            check_eq("out_resp.branch_taken", out_resp.branch_taken, taken);
            check_eq("out_resp.branch_target", out_resp.branch_target, req.branch_target);
            check_eq("out_resp.branch_mistaken", out_resp.branch_mistaken,
                     taken != i[2] || (taken && !i[3]));
        end
        for (int i = 0; i < 4; i++) begin
            req = make_req(isa_pkg::op_add, next_random(), next_random() & 32'hffc);
            req.is_branch   = 1'b1;
            req.is_jirl     = 1'b1;
            req.pred_taken  = i[0];
            req.pred_target = req.src1 + req.src2 + (i[1] ? 32'd0 : 32'd4);
            issue(req);
            check_eq("out_valid", out_valid, 1'b1);
            check_resp(req, req.pc + 32'd4);
            check_eq("out_resp.branch_taken", out_resp.branch_taken, 1'b1);
            check_eq("out_resp.branch_target", out_resp.branch_target, req.src1 + req.src2);
            check_eq("out_resp.branch_mistaken", out_resp.branch_mistaken, !i[0] || !i[1]);
        end
    endtask

    task automatic test_backpressure();
        ex_pkg::ex_req_t first;
        ex_pkg::ex_req_t second;
        first  = make_req(isa_pkg::op_xor, next_random(), next_random());
        second = make_req(isa_pkg::op_sub, next_random(), next_random());
        // Let the last instruction leave before closing the output.
        @(negedge clk);
        allowout = 1'b0;
        issue(first);
        in_valid = 1'b1;
        in_req   = second;
        repeat (6) begin
            check_eq("out_valid", out_valid, 1'b1);
            check_eq("stall", stall, 1'b1);
            check_resp(first, alu_model(first.opcode, first.src1, first.src2));
            @(negedge clk);
        end
        allowout = 1'b1;
        @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
        check_eq("out_valid", out_valid, 1'b1);
        check_resp(second, alu_model(second.opcode, second.src1, second.src2));
    endtask

    task automatic test_flush();
        ex_pkg::ex_req_t req;
        @(negedge clk);
        issue(make_req(isa_pkg::op_div, next_random(), 32'd7));
        repeat (5) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (40) begin
            check_eq("out_valid", out_valid, 1'b0);
            check_eq("stall", stall, 1'b0);
            @(negedge clk);
        end
        req = make_req(isa_pkg::op_add, next_random(), next_random());
        issue(req);
        check_eq("out_valid", out_valid, 1'b1);
        check_resp(req, req.src1 + req.src2);
    endtask

    initial begin
        rng_state = 32'h16f277b4;
        clk       = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        allowout  = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_alu();
        test_muldiv();
        test_branches();
        test_backpressure();
        test_flush();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== ex_stage.f ====
hw/isa_pkg.sv
hw/ex_pkg.sv
hw/div_counter.sv
hw/alu.sv
hw/muldiv_unit.sv
hw/branch_unit.sv
hw/ex_ctrl.sv
hw/ex_stage.sv
bench/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - hw/isa_pkg.sv
  - hw/ex_pkg.sv
  - hw/div_counter.sv
  - hw/alu.sv
  - hw/muldiv_unit.sv
  - hw/branch_unit.sv
  - hw/ex_ctrl.sv
  - hw/ex_stage.sv
  - target: simulation
    files:
      - bench/ex_stage_tb.sv
